//--- apb_gpio.sv
/*
  APB GPIO: direction and output registers, synchronised
  inputs, per-pin rising edge interrupt with clear on read
*/
`timescale 1ns/10ps
`include "soc_periph_consts.svh"

module apb_gpio
  import soc_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pslverr_o,

  input  gpio_vec_t gpio_in_i,
  output gpio_vec_t gpio_out_o,
  output gpio_vec_t gpio_oe_o,
  output logic      gpio_irq_o
);

  logic [`SLV_SEL_LSB-1:0] reg_off;
  logic                    apb_wr;
  logic                    status_rd;
  logic                    off_bad;

  // two flop synchroniser plus one for edge history
  gpio_vec_t gpio_sync1;
  gpio_vec_t gpio_sync2;
  gpio_vec_t gpio_prev;
  gpio_vec_t irq_en;
  gpio_vec_t irq_status;
  gpio_vec_t rise;

  assign reg_off   = paddr_i[`SLV_SEL_LSB-1:0];
  assign apb_wr    = psel_i & penable_i & pwrite_i;
  assign status_rd = psel_i & penable_i & ~pwrite_i & (reg_off == `REG_GPIO_IRQ_STATUS);

  // rising edge on enabled pins only
  assign rise = gpio_sync2 & ~gpio_prev & irq_en;

  ////////////////////////////////////////
  // input path and interrupt
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_sync1 <= '0;
      gpio_sync2 <= '0;
      gpio_prev  <= '0;
      irq_status <= '0;
    end else begin
      gpio_sync1 <= gpio_in_i;
      gpio_sync2 <= gpio_sync1;
      gpio_prev  <= gpio_sync2;
      // a new edge in the read cycle survives the clear
      irq_status <= (status_rd ? '0 : irq_status) | rise;
    end
  end

  assign gpio_irq_o = |irq_status;

  ////////////////////////////////////////
  // config registers
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_oe_o  <= '0;
      gpio_out_o <= '0;
      irq_en     <= '0;
    end else if (apb_wr) begin
      case (reg_off)
        `REG_GPIO_DIR:    gpio_oe_o  <= pwdata_i;
        `REG_GPIO_OUT:    gpio_out_o <= pwdata_i;
        `REG_GPIO_IRQ_EN: irq_en     <= pwdata_i;
        // input and status take no write
        default: ;
      endcase
    end
  end

  // read mux
  always_comb begin
    prdata_o = '0;
    off_bad  = 1'b0;
    case (reg_off)
      `REG_GPIO_DIR:        prdata_o = gpio_oe_o;
      `REG_GPIO_IN:         prdata_o = gpio_sync2;
      `REG_GPIO_OUT:        prdata_o = gpio_out_o;
      `REG_GPIO_IRQ_EN:     prdata_o = irq_en;
      `REG_GPIO_IRQ_STATUS: prdata_o = irq_status;
      default:              off_bad  = 1'b1;
    endcase
  end

  assign pslverr_o = psel_i & penable_i & off_bad;

endmodule

//--- apb_periph_demux.sv
/*
  APB peripheral demux: picks a slave from address bits 11:8,
  returns its read data and error, flags unmapped slaves
*/
`timescale 1ns/10ps
`include "soc_periph_consts.svh"

module apb_periph_demux
  import soc_periph_pkg::*;
(
  input  apb_addr_t  paddr_i,
  input  logic       psel_i,
  input  logic       penable_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,

  // per-slave side
  output logic [2:0] sel_o,
  input  apb_data_t  slv_prdata_i [3],
  input  logic [2:0] slv_pslverr_i
);

  // slave number field
  logic [3:0] slv_num;
  logic       slv_hit;
  logic       slv_err;

  assign slv_num = paddr_i[`SLV_SEL_LSB+3:`SLV_SEL_LSB];

  ////////////////////////////////////////
  // decode and response mux
  ////////////////////////////////////////
  always_comb begin
    sel_o    = '0;
    prdata_o = '0;
    slv_hit  = 1'b0;
    slv_err  = 1'b0;
    case (slv_num)
      `SLV_SOC_CTRL: begin
        slv_hit                = 1'b1;
        sel_o[`SLV_SOC_CTRL]   = psel_i;
        prdata_o               = slv_prdata_i[`SLV_SOC_CTRL];
        slv_err                = slv_pslverr_i[`SLV_SOC_CTRL];
      end
      `SLV_GPIO: begin
        slv_hit                = 1'b1;
        sel_o[`SLV_GPIO]       = psel_i;
        prdata_o               = slv_prdata_i[`SLV_GPIO];
        slv_err                = slv_pslverr_i[`SLV_GPIO];
      end
      `SLV_EVT: begin
        slv_hit                = 1'b1;
        sel_o[`SLV_EVT]        = psel_i;
        prdata_o               = slv_prdata_i[`SLV_EVT];
        slv_err                = slv_pslverr_i[`SLV_EVT];
      end
      // unmapped slaves read as zero
      default: begin
        slv_hit  = 1'b0;
      end
    endcase
  end

  // error from the chosen slave, or no slave at all
  assign pslverr_o = psel_i & penable_i & (slv_err | ~slv_hit);

  // all slaves are zero wait state
  assign pready_o = 1'b1;

endmodule

//--- compile.f
+incdir+.
soc_periph_pkg.sv
apb_periph_demux.sv
soc_ctrl_regs.sv
apb_gpio.sv
soc_event_gen.sv
soc_peripherals.sv
soc_periph_chk.sv
tb_soc_peripherals.sv

//--- run_sim.sh
#!/bin/sh
# build and run the SoC peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_peripherals -f compile.f -o tb_soc_peripherals
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_peripherals > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- soc_ctrl_regs.sv
/*
  SoC control registers: fabric controller boot address and
  fetch enable, JTAG mailbox, read-only core count info
*/
`timescale 1ns/10ps
`include "soc_periph_consts.svh"

module soc_ctrl_regs
  import soc_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  output logic       pslverr_o,

  input  logic       fc_fetch_en_valid_i,
  input  logic       fc_fetch_en_i,
  output apb_addr_t  fc_bootaddr_o,
  output logic       fc_fetchen_o,
  input  logic [7:0] soc_jtag_reg_i,
  output logic [7:0] soc_jtag_reg_o
);

  logic [`SLV_SEL_LSB-1:0] reg_off;
  logic                    apb_wr;
  logic                    off_bad;

  assign reg_off = paddr_i[`SLV_SEL_LSB-1:0];
  // write lands at the end of the access cycle
  assign apb_wr  = psel_i & penable_i & pwrite_i;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fc_bootaddr_o  <= `BOOT_ADDR_RESET;
      fc_fetchen_o   <= 1'b0;
      soc_jtag_reg_o <= '0;
    end else begin
      if (apb_wr && reg_off == `REG_BOOTADDR) begin
        fc_bootaddr_o <= pwdata_i;
      end
      // external strobe wins over the bus
      if (fc_fetch_en_valid_i) begin
        fc_fetchen_o <= fc_fetch_en_i;
      end else if (apb_wr && reg_off == `REG_FETCHEN) begin
        fc_fetchen_o <= pwdata_i[0];
      end
      if (apb_wr && reg_off == `REG_JTAG) begin
        soc_jtag_reg_o <= pwdata_i[7:0];
      end
    end
  end

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////
  always_comb begin
    prdata_o = '0;
    off_bad  = 1'b0;
    case (reg_off)
      `REG_BOOTADDR: prdata_o = fc_bootaddr_o;
      `REG_FETCHEN:  prdata_o[0] = fc_fetchen_o;
      // debugger byte above, soc byte below
      `REG_JTAG:     prdata_o[15:0] = {soc_jtag_reg_i, soc_jtag_reg_o};
      `REG_INFO:     prdata_o = {16'(`NB_CORES), 16'(`NB_CLUSTERS)};
      default:       off_bad = 1'b1;
    endcase
  end

  // info word is read only
  assign pslverr_o = psel_i & penable_i &
                     (off_bad | (pwrite_i & reg_off == `REG_INFO));

endmodule

//--- soc_event_gen.sv
/*
  SoC event generator: arbitrates software, GPIO and ref clock
  events into a small FIFO, offered on a valid/ready port
*/
`timescale 1ns/10ps
`include "soc_periph_consts.svh"

module soc_event_gen
  import soc_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pslverr_o,

  input  logic      slow_clk_i,
  input  logic      gpio_irq_i,
  output logic      ref_edge_o,
  output logic      overflow_o,
  output logic      fc_event_valid_o,
  output evt_id_t   fc_event_data_o,
  input  logic      fc_event_ready_i
);

  localparam int PTR_W = $clog2(`EVT_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [`SLV_SEL_LSB-1:0] reg_off;
  logic                    apb_wr;
  logic                    off_bad;
  logic [1:0]              evt_mask;
  // slow clock sync, last stage is edge history
  logic [2:0]              ref_sync;
  logic                    ref_rise_q;
  logic                    ref_fall_q;
  logic                    gpio_irq_q;
  logic                    sw_cand, gpio_cand, rise_cand, fall_cand;
  logic                    push_req, push_ok, pop, lost;
  evt_id_t                 push_id;
  evt_id_t                 fifo_mem [`EVT_FIFO_DEPTH];
  logic [PTR_W-1:0]        wr_ptr, rd_ptr;
  logic [CNT_W-1:0]        fill_cnt;

  assign reg_off = paddr_i[`SLV_SEL_LSB-1:0];
  assign apb_wr  = psel_i & penable_i & pwrite_i;

  ////////////////////////////////////////
  // event sources
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ref_sync   <= '0;
      ref_rise_q <= 1'b0;
      ref_fall_q <= 1'b0;
      gpio_irq_q <= 1'b0;
    end else begin
      ref_sync   <= {ref_sync[1:0], slow_clk_i};
      // one cycle pulses on the third edge
      ref_rise_q <= ref_sync[1] & ~ref_sync[2];
      ref_fall_q <= ~ref_sync[1] & ref_sync[2];
      gpio_irq_q <= gpio_irq_i;
    end
  end

  assign ref_edge_o = ref_rise_q | ref_fall_q;
  assign sw_cand    = apb_wr & (reg_off == `REG_EVT_SW);
  assign gpio_cand  = evt_mask[0] & gpio_irq_i & ~gpio_irq_q;
  assign rise_cand  = evt_mask[1] & ref_rise_q;
  assign fall_cand  = evt_mask[1] & ref_fall_q;

  // priority: software, gpio, ref edges
  always_comb begin
    push_id = `EVT_ID_REF_FALL;
    if (sw_cand)        push_id = pwdata_i[`EVNT_WIDTH-1:0];
    else if (gpio_cand) push_id = `EVT_ID_GPIO;
    else if (rise_cand) push_id = `EVT_ID_REF_RISE;
  end

  assign push_req = sw_cand | gpio_cand | rise_cand | fall_cand;
  assign pop      = fc_event_valid_o & fc_event_ready_i;
  // a full fifo still takes a push when it pops the same edge
  assign push_ok  = (fill_cnt != CNT_W'(`EVT_FIFO_DEPTH)) | pop;
  // losing candidates or a blocked push
  assign lost     = (sw_cand & (gpio_cand | rise_cand | fall_cand)) |
                    (gpio_cand & (rise_cand | fall_cand)) | (push_req & ~push_ok);

  ////////////////////////////////////////
  // fifo, mask and overflow
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (push_req && push_ok) fifo_mem[wr_ptr] <= push_id;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_cnt   <= '0;
      evt_mask   <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push_req && push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      fill_cnt <= fill_cnt + CNT_W'(push_req & push_ok) - CNT_W'(pop);
      if (apb_wr && reg_off == `REG_EVT_MASK) evt_mask <= pwdata_i[1:0];
      // new loss beats the clear
      if (lost) overflow_o <= 1'b1;
      else if (apb_wr && reg_off == `REG_EVT_STATUS) overflow_o <= 1'b0;
    end
  end

  assign fc_event_valid_o = (fill_cnt != '0);
  assign fc_event_data_o  = fifo_mem[rd_ptr];

  // read mux, sw register reads zero
  always_comb begin
    prdata_o = '0;
    off_bad  = 1'b0;
    case (reg_off)
      `REG_EVT_SW:     prdata_o = '0;
      `REG_EVT_MASK:   prdata_o[1:0] = evt_mask;
      `REG_EVT_STATUS: prdata_o[CNT_W:0] = {fill_cnt, overflow_o};
      default:         off_bad = 1'b1;
    endcase
  end

  assign pslverr_o = psel_i & penable_i & off_bad;

endmodule

//--- soc_periph_chk.sv
/*
  Port checks for the SoC peripheral corner: stalled events hold,
  no bus error while idle, event port empty after reset
*/
`timescale 1ns/10ps

module soc_periph_chk
  import soc_periph_pkg::*;
(
  input logic    clk_i,
  input logic    reset_i,
  input logic    psel_i,
  input logic    pslverr_o,
  input logic    fc_event_valid_o,
  input logic    fc_event_ready_i,
  input evt_id_t fc_event_data_o
);

  // stalled event keeps valid and its id
  a_evt_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    fc_event_valid_o && !fc_event_ready_i |=> fc_event_valid_o && $stable(fc_event_data_o))
    else $error("event port dropped or changed a stalled event");

  // error only inside a selected transfer
  a_err_idle: assert property (@(posedge clk_i) !psel_i |-> !pslverr_o)
    else $error("pslverr high without psel");

  a_rst_empty: assert property (@(posedge clk_i) reset_i |=> !fc_event_valid_o)
    else $error("event valid high right after reset");

endmodule

//--- soc_periph_consts.svh
/*
  SoC peripheral constants: bus widths, address map,
  register offsets, reset values and event numbering
*/
`ifndef SOC_PERIPH_CONSTS_SVH
`define SOC_PERIPH_CONSTS_SVH

// bus and vector widths
`define APB_ADDR_W          32
`define APB_DATA_W          32
`define N_GPIO              32
`define EVNT_WIDTH          8
`define EVT_FIFO_DEPTH      4

// address bits 11:8 pick the slave, 7:0 the register
`define SLV_SEL_LSB         8
`define SLV_SOC_CTRL        0
`define SLV_GPIO            1
`define SLV_EVT             2

// soc control offsets
`define REG_BOOTADDR        8'h00
`define REG_FETCHEN         8'h04
`define REG_JTAG            8'h08
`define REG_INFO            8'h0C

// gpio offsets
`define REG_GPIO_DIR        8'h00
`define REG_GPIO_IN         8'h04
`define REG_GPIO_OUT        8'h08
`define REG_GPIO_IRQ_EN     8'h0C
`define REG_GPIO_IRQ_STATUS 8'h10

// event generator offsets
`define REG_EVT_SW          8'h00
`define REG_EVT_MASK        8'h04
`define REG_EVT_STATUS      8'h08

`define BOOT_ADDR_RESET     32'h1C008080
`define NB_CORES            4
`define NB_CLUSTERS         0

// event ids pushed into the fifo
`define EVT_ID_GPIO         8'h18
`define EVT_ID_REF_RISE     8'h17
`define EVT_ID_REF_FALL     8'h16

// positions in the fc interrupt vector
`define FC_EVT_GPIO_BIT     18
`define FC_EVT_REF_BIT      23
`define FC_EVT_ERR_BIT      29

`endif

//--- soc_periph_pkg.sv
/*
  SoC peripheral types shared by the register blocks
*/
`include "soc_periph_consts.svh"

package soc_periph_pkg;

  ////////////////////////////////////////
  // apb bus words
  ////////////////////////////////////////
  typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [`APB_DATA_W-1:0] apb_data_t;

  ////////////////////////////////////////
  // event and pin vectors
  ////////////////////////////////////////
  // id carried on the fc event port
  typedef logic [`EVNT_WIDTH-1:0] evt_id_t;

  // one bit per pad
  typedef logic [`N_GPIO-1:0] gpio_vec_t;

endpackage

//--- soc_peripherals.sv
/*
  SoC peripheral corner: one APB port to SoC control, GPIO and
  event generator, plus the fc interrupt line vector
*/
`timescale 1ns/10ps
`include "soc_periph_consts.svh"

module soc_peripherals
  import soc_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       slow_clk_i,
  // apb slave port
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  input  logic       pwrite_i,
  input  logic       psel_i,
  input  logic       penable_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,
  // fabric controller boot
  input  logic       fc_fetch_en_valid_i,
  input  logic       fc_fetch_en_i,
  output apb_addr_t  fc_bootaddr_o,
  output logic       fc_fetchen_o,
  input  logic [7:0] soc_jtag_reg_i,
  output logic [7:0] soc_jtag_reg_o,
  // pads
  input  gpio_vec_t  gpio_in_i,
  output gpio_vec_t  gpio_out_o,
  output gpio_vec_t  gpio_oe_o,
  // events
  output apb_data_t  fc_events_o,
  output logic       fc_event_valid_o,
  output evt_id_t    fc_event_data_o,
  input  logic       fc_event_ready_i
);

  localparam int N_SLV = `SLV_EVT + 1;

  logic [N_SLV-1:0] s_sel;
  apb_data_t        s_slv_prdata [N_SLV];
  logic [N_SLV-1:0] s_slv_pslverr;
  logic             s_gpio_irq;
  logic             s_ref_edge;
  logic             s_overflow;

  ////////////////////////////////////////
  // bus decode
  ////////////////////////////////////////
  apb_periph_demux u_apb_periph_demux (
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .sel_o        (s_sel),
    .slv_prdata_i (s_slv_prdata),
    .slv_pslverr_i(s_slv_pslverr)
  );

  ////////////////////////////////////////
  // slaves
  ////////////////////////////////////////
  soc_ctrl_regs u_soc_ctrl_regs (
    .clk_i(clk_i), .reset_i(reset_i),
    .psel_i(s_sel[`SLV_SOC_CTRL]), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(s_slv_prdata[`SLV_SOC_CTRL]), .pslverr_o(s_slv_pslverr[`SLV_SOC_CTRL]),
    .fc_fetch_en_valid_i(fc_fetch_en_valid_i), .fc_fetch_en_i(fc_fetch_en_i),
    .fc_bootaddr_o(fc_bootaddr_o), .fc_fetchen_o(fc_fetchen_o),
    .soc_jtag_reg_i(soc_jtag_reg_i), .soc_jtag_reg_o(soc_jtag_reg_o)
  );

  apb_gpio u_apb_gpio (
    .clk_i(clk_i), .reset_i(reset_i),
    .psel_i(s_sel[`SLV_GPIO]), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(s_slv_prdata[`SLV_GPIO]), .pslverr_o(s_slv_pslverr[`SLV_GPIO]),
    .gpio_in_i(gpio_in_i), .gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o),
    .gpio_irq_o(s_gpio_irq)
  );

  soc_event_gen u_soc_event_gen (
    .clk_i(clk_i), .reset_i(reset_i),
    .psel_i(s_sel[`SLV_EVT]), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(s_slv_prdata[`SLV_EVT]), .pslverr_o(s_slv_pslverr[`SLV_EVT]),
    .slow_clk_i(slow_clk_i), .gpio_irq_i(s_gpio_irq),
    .ref_edge_o(s_ref_edge), .overflow_o(s_overflow),
    .fc_event_valid_o(fc_event_valid_o), .fc_event_data_o(fc_event_data_o),
    .fc_event_ready_i(fc_event_ready_i)
  );

  // fc interrupt lines, unused bits tied low
  always_comb begin
    fc_events_o                  = '0;
    fc_events_o[`FC_EVT_GPIO_BIT] = s_gpio_irq;
    fc_events_o[`FC_EVT_REF_BIT]  = s_ref_edge;
    fc_events_o[`FC_EVT_ERR_BIT]  = s_overflow;
  end

endmodule

//--- tb_soc_peripherals.sv
/*
  Testbench for the SoC peripheral corner: directed tests for SoC control,
  bus errors, GPIO and the event generator over APB and the event port
*/
`timescale 1ns/10ps
`include "soc_periph_consts.svh"

module tb_soc_peripherals
  import soc_periph_pkg::*;
;

  // about 1200 cycles of tests, generous margin on top
  localparam int TEST_CYCLES    = 1200;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 5 / 2;
  // quarter period after the falling edge, inputs settled
  localparam int SAMPLE_DLY     = 5;

  logic       clk_i;
  logic       reset_i;
  logic       slow_clk_i;
  apb_addr_t  paddr_i;
  apb_data_t  pwdata_i;
  logic       pwrite_i;
  logic       psel_i;
  logic       penable_i;
  apb_data_t  prdata_o;
  logic       pready_o;
  logic       pslverr_o;
  logic       fc_fetch_en_valid_i;
  logic       fc_fetch_en_i;
  apb_addr_t  fc_bootaddr_o;
  logic       fc_fetchen_o;
  logic [7:0] soc_jtag_reg_i;
  logic [7:0] soc_jtag_reg_o;
  gpio_vec_t  gpio_in_i;
  gpio_vec_t  gpio_out_o;
  gpio_vec_t  gpio_oe_o;
  apb_data_t  fc_events_o;
  logic       fc_event_valid_o;
  evt_id_t    fc_event_data_o;
  logic       fc_event_ready_i;

  int         err_cnt;
  int         cycle_cnt;

  soc_peripherals u_soc_peripherals (.*);

  // port checks ride on the DUT
  bind soc_peripherals soc_periph_chk u_soc_periph_chk (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .psel_i          (psel_i),
    .pslverr_o       (pslverr_o),
    .fc_event_valid_o(fc_event_valid_o),
    .fc_event_ready_i(fc_event_ready_i),
    .fc_event_data_o (fc_event_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_evt(input string name, input evt_id_t got, input evt_id_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_gpio(input string name, input gpio_vec_t got, input gpio_vec_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // bus and event port drivers
  ////////////////////////////////////////
  // slave number in bits 11:8, offset below
  function automatic apb_addr_t reg_addr(input int slv, input logic [7:0] off);
    return (apb_addr_t'(slv) << `SLV_SEL_LSB) | apb_addr_t'(off);
  endfunction

  // called on a falling edge, returns on one
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    paddr_i   = addr;
    pwdata_i  = data;
    pwrite_i  = 1'b1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk_i);
    penable_i = 1'b1;
    #SAMPLE_DLY;
    while (!pready_o) begin
      @(negedge clk_i);
      #SAMPLE_DLY;
    end
    err = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    paddr_i   = addr;
    pwrite_i  = 1'b0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk_i);
    penable_i = 1'b1;
    #SAMPLE_DLY;
    while (!pready_o) begin
      @(negedge clk_i);
      #SAMPLE_DLY;
    end
    // read data is combinational in the access cycle
    data = prdata_o;
    err  = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // takes one event off the port, ready once valid
  task automatic pop_event(output evt_id_t id);
    while (!fc_event_valid_o) @(negedge clk_i);
    id = fc_event_data_o;
    fc_event_ready_i = 1'b1;
    @(negedge clk_i);
    fc_event_ready_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic boot_and_mailbox();
    apb_data_t  boot;
    apb_data_t  rd;
    logic       err;
    logic [7:0] jtag_in;
    logic [7:0] jtag_wr;
    check_data("fc_bootaddr_o", fc_bootaddr_o, `BOOT_ADDR_RESET);
    check_data("fc_fetchen_o", apb_data_t'(fc_fetchen_o), 32'h0);
    boot = $urandom;
    apb_write(reg_addr(`SLV_SOC_CTRL, `REG_BOOTADDR), boot, err);
    apb_write(reg_addr(`SLV_SOC_CTRL, `REG_FETCHEN), 32'h1, err);
    check_data("fc_bootaddr_o", fc_bootaddr_o, boot);
    check_data("fc_fetchen_o", apb_data_t'(fc_fetchen_o), 32'h1);
    apb_read(reg_addr(`SLV_SOC_CTRL, `REG_BOOTADDR), rd, err);
    check_data("prdata_o bootaddr", rd, boot);
    apb_read(reg_addr(`SLV_SOC_CTRL, `REG_FETCHEN), rd, err);
    check_data("prdata_o fetchen", rd, 32'h1);
    // external strobe clears fetch enable
    fc_fetch_en_valid_i = 1'b1;
    fc_fetch_en_i       = 1'b0;
    @(negedge clk_i);
    fc_fetch_en_valid_i = 1'b0;
    check_data("fc_fetchen_o", apb_data_t'(fc_fetchen_o), 32'h0);
    // mailbox, debugger byte on top
    jtag_in        = 8'($urandom);
    jtag_wr        = 8'($urandom);
    soc_jtag_reg_i = jtag_in;
    apb_write(reg_addr(`SLV_SOC_CTRL, `REG_JTAG), apb_data_t'(jtag_wr), err);
    check_data("soc_jtag_reg_o", apb_data_t'(soc_jtag_reg_o), apb_data_t'(jtag_wr));
    apb_read(reg_addr(`SLV_SOC_CTRL, `REG_JTAG), rd, err);
    check_data("prdata_o jtag", rd, {16'h0, jtag_in, jtag_wr});
    apb_read(reg_addr(`SLV_SOC_CTRL, `REG_INFO), rd, err);
    check_data("prdata_o info", rd, (32'(`NB_CORES) << 16) | 32'(`NB_CLUSTERS));
    check_data("pslverr_o info read", apb_data_t'(err), 32'h0);
  endtask

  task automatic bus_errors();
    apb_data_t rd;
    logic      err;
    // no slave behind number 5
    apb_read(reg_addr(5, 8'h00), rd, err);
    check_data("pslverr_o slave 5", apb_data_t'(err), 32'h1);
    check_data("prdata_o slave 5", rd, 32'h0);
    apb_read(reg_addr(`SLV_GPIO, 8'h14), rd, err);
    check_data("pslverr_o gpio offset", apb_data_t'(err), 32'h1);
    apb_write(reg_addr(`SLV_SOC_CTRL, `REG_INFO), $urandom, err);
    check_data("pslverr_o info write", apb_data_t'(err), 32'h1);
  endtask

  task automatic gpio_pins_and_irq();
    gpio_vec_t dir;
    gpio_vec_t out;
    gpio_vec_t pins;
    apb_data_t rd;
    logic      err;
    dir = $urandom;
    out = $urandom;
    apb_write(reg_addr(`SLV_GPIO, `REG_GPIO_DIR), dir, err);
    apb_write(reg_addr(`SLV_GPIO, `REG_GPIO_OUT), out, err);
    check_gpio("gpio_oe_o", gpio_oe_o, dir);
    check_gpio("gpio_out_o", gpio_out_o, out);
    // pin 5 stays low until the irq part
    pins      = $urandom & ~(32'h1 << 5);
    gpio_in_i = pins;
    repeat (2) @(negedge clk_i);
    apb_read(reg_addr(`SLV_GPIO, `REG_GPIO_IN), rd, err);
    check_gpio("prdata_o gpio in", rd, pins);
    apb_write(reg_addr(`SLV_GPIO, `REG_GPIO_IRQ_EN), 32'h1 << 5, err);
    gpio_in_i = pins | (32'h1 << 5);
    repeat (2) @(negedge clk_i);
    check_data("fc_events_o early", fc_events_o, 32'h0);
    @(negedge clk_i);
    check_data("fc_events_o gpio", fc_events_o, 32'h1 << `FC_EVT_GPIO_BIT);
    apb_read(reg_addr(`SLV_GPIO, `REG_GPIO_IRQ_STATUS), rd, err);
    check_gpio("prdata_o irq status", rd, 32'h1 << 5);
    // status cleared by the first read
    apb_read(reg_addr(`SLV_GPIO, `REG_GPIO_IRQ_STATUS), rd, err);
    check_gpio("prdata_o irq status", rd, 32'h0);
    check_data("fc_events_o cleared", fc_events_o, 32'h0);
  endtask

  task automatic sw_event_backpressure();
    evt_id_t   ids [6];
    evt_id_t   got;
    apb_data_t rd;
    logic      err;
    fc_event_ready_i = 1'b0;
    foreach (ids[i]) begin
      ids[i] = 8'($urandom);
      apb_write(reg_addr(`SLV_EVT, `REG_EVT_SW), apb_data_t'(ids[i]), err);
      check_data("fc_event_valid_o", apb_data_t'(fc_event_valid_o), 32'h1);
      check_evt("fc_event_data_o", fc_event_data_o, ids[0]);
    end
    // full fifo plus two lost writes
    apb_read(reg_addr(`SLV_EVT, `REG_EVT_STATUS), rd, err);
    check_data("prdata_o evt status", rd, (32'(`EVT_FIFO_DEPTH) << 1) | 32'h1);
    check_data("fc_events_o overflow", fc_events_o, 32'h1 << `FC_EVT_ERR_BIT);
    for (int i = 0; i < `EVT_FIFO_DEPTH; i++) begin
      pop_event(got);
      check_evt("fc_event_data_o", got, ids[i]);
    end
    check_data("fc_event_valid_o", apb_data_t'(fc_event_valid_o), 32'h0);
    apb_write(reg_addr(`SLV_EVT, `REG_EVT_STATUS), $urandom, err);
    apb_read(reg_addr(`SLV_EVT, `REG_EVT_STATUS), rd, err);
    check_data("prdata_o evt status", rd, 32'h0);
    check_data("fc_events_o cleared", fc_events_o, 32'h0);
  endtask

  task automatic hw_event_sources();
    evt_id_t   got;
    apb_data_t rd;
    logic      err;
    apb_write(reg_addr(`SLV_EVT, `REG_EVT_MASK), 32'h3, err);
    // ref rise, pulse on the third edge
    slow_clk_i = 1'b1;
    repeat (3) @(negedge clk_i);
    check_data("fc_events_o ref", fc_events_o, 32'h1 << `FC_EVT_REF_BIT);
    @(negedge clk_i);
    check_data("fc_events_o ref", fc_events_o, 32'h0);
    pop_event(got);
    check_evt("fc_event_data_o", got, `EVT_ID_REF_RISE);
    slow_clk_i = 1'b0;
    repeat (3) @(negedge clk_i);
    check_data("fc_events_o ref", fc_events_o, 32'h1 << `FC_EVT_REF_BIT);
    pop_event(got);
    check_evt("fc_event_data_o", got, `EVT_ID_REF_FALL);
    // fresh rise on pin 5
    gpio_in_i[5] = 1'b0;
    repeat (4) @(negedge clk_i);
    gpio_in_i[5] = 1'b1;
    pop_event(got);
    check_evt("fc_event_data_o", got, `EVT_ID_GPIO);
    apb_read(reg_addr(`SLV_GPIO, `REG_GPIO_IRQ_STATUS), rd, err);
    check_gpio("prdata_o irq status", rd, 32'h1 << 5);
    // masked sources stay quiet
    apb_write(reg_addr(`SLV_EVT, `REG_EVT_MASK), 32'h0, err);
    slow_clk_i = 1'b1;
    repeat (6) @(negedge clk_i);
    slow_clk_i = 1'b0;
    gpio_in_i[5] = 1'b0;
    repeat (6) @(negedge clk_i);
    gpio_in_i[5] = 1'b1;
    repeat (6) @(negedge clk_i);
    check_data("fc_event_valid_o masked", apb_data_t'(fc_event_valid_o), 32'h0);
    // the pin interrupt itself still fires
    apb_read(reg_addr(`SLV_GPIO, `REG_GPIO_IRQ_STATUS), rd, err);
    check_gpio("prdata_o irq status", rd, 32'h1 << 5);
    apb_read(reg_addr(`SLV_EVT, `REG_EVT_STATUS), rd, err);
    check_data("prdata_o evt status", rd, 32'h0);
  endtask

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: tests still running after %0d cycles", cycle_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    err_cnt             = 0;
    reset_i             = 1'b1;
    slow_clk_i          = 1'b0;
    paddr_i             = '0;
    pwdata_i            = '0;
    pwrite_i            = 1'b0;
    psel_i              = 1'b0;
    penable_i           = 1'b0;
    fc_fetch_en_valid_i = 1'b0;
    fc_fetch_en_i       = 1'b0;
    soc_jtag_reg_i      = '0;
    gpio_in_i           = '0;
    fc_event_ready_i    = 1'b0;
    void'($urandom(87));
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    boot_and_mailbox();
    bus_errors();
    gpio_pins_and_irq();
    sw_event_backpressure();
    hw_event_sources();
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
